// File: hw/ex_alu.sv
//==================================================
// Combinational integer ALU
// Logic, shift and compare operations on two operands
//==================================================
`default_nettype none

`include "ex_settings.svh"

module ex_alu
  import ex_pkg::*;
(
  input  alu_func_e                  func,
  input  logic [`EX_DATA_WIDTH-1:0]  opa,
  input  logic [`EX_DATA_WIDTH-1:0]  opb,
  output logic [`EX_DATA_WIDTH-1:0]  result
);

  localparam int data_width = `EX_DATA_WIDTH;
  localparam int shift_bits = $clog2(data_width);

  logic [shift_bits-1:0] shamt;

  // Shift amount is the low bits of opb only
  assign shamt = opb[shift_bits-1:0];

  // Same sign compares like unsigned, otherwise the negative one is smaller
  function automatic logic signed_lt(input logic [data_width-1:0] a,
                                     input logic [data_width-1:0] b);
    if (a[data_width-1] == b[data_width-1]) begin
      return a < b;
    end
    return a[data_width-1];
  endfunction

  always_comb begin
    case (func)
      alu_addq:   result = opa + opb;
      alu_subq:   result = opa - opb;
      alu_and:    result = opa & opb;
      alu_bic:    result = opa & ~opb;
      alu_bis:    result = opa | opb;
      alu_ornot:  result = opa | ~opb;
      alu_xor:    result = opa ^ opb;
      alu_eqv:    result = opa ^ ~opb;
      alu_srl:    result = opa >> shamt;
      alu_sll:    result = opa << shamt;
      // Logical shift, then fill the vacated top bits with the sign
      alu_sra:    result = (opa >> shamt) |
                           ({data_width{opa[data_width-1]}} << (data_width - shamt));
      alu_cmpult: result = {{(data_width-1){1'b0}}, (opa < opb)};
      alu_cmpeq:  result = {{(data_width-1){1'b0}}, (opa == opb)};
      alu_cmpule: result = {{(data_width-1){1'b0}}, (opa <= opb)};
      alu_cmplt:  result = {{(data_width-1){1'b0}}, signed_lt(opa, opb)};
      alu_cmple:  result = {{(data_width-1){1'b0}}, (signed_lt(opa, opb) || (opa == opb))};
      default:    result = `EX_ALU_MARKER;
    endcase
  end

  always_comb begin
    assert (!$isunknown(func))
      else $error("ex_alu: unknown function code");
  end

endmodule

`default_nettype wire

// File: hw/ex_branch_unit.sv
//==================================================
// Branch condition and result code
// Mispredict check and halt detection
//==================================================
`default_nettype none

`include "ex_settings.svh"

module ex_branch_unit
  import ex_pkg::*;
(
  input  ex_issue_t       issue,
  output logic            mispredict,
  output branch_result_e  branch_result
);

  logic cond;
  logic taken;

  // br_func[2] negates the condition on opa
  always_comb begin
    case (issue.br_func[1:0])
      2'b00:   cond = ~issue.opa[0];
      2'b01:   cond = (issue.opa == '0);
      2'b10:   cond = issue.opa[`EX_DATA_WIDTH-1];
      default: cond = issue.opa[`EX_DATA_WIDTH-1] || (issue.opa == '0);
    endcase
    taken = cond ^ issue.br_func[2];
  end

  always_comb begin
    mispredict    = 1'b0;
    branch_result = branch_none;
    if (issue.valid && issue.is_branch) begin
      branch_result = taken ? branch_taken : branch_not_taken;
      mispredict    = (taken != issue.predicted_taken);
    end else if (issue.valid && (issue.ir == `EX_HALT_INSTRUCTION)) begin
      branch_result = branch_halt;
    end
  end

  always_comb begin
    assert (!(issue.valid && issue.is_branch && issue.is_mult))
      else $error("ex_branch_unit: issue flagged as both branch and multiply");
  end

endmodule

`default_nettype wire

// File: hw/ex_mult.sv
//==================================================
// Pipelined multiplier, low half of the product
// Chain of slices carrying tag and valid
//==================================================
`default_nettype none

`include "ex_settings.svh"

module ex_mult
  import ex_pkg::*;
(
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       start,
  input  logic                       hold,
  input  logic [`EX_DATA_WIDTH-1:0]  mplier,
  input  logic [`EX_DATA_WIDTH-1:0]  mcand,
  input  mult_tag_t                  tag_in,
  output logic [`EX_DATA_WIDTH-1:0]  product,
  output mult_tag_t                  tag_out,
  output logic                       valid_out
);

  localparam int stages = `EX_MULT_STAGES;

  // Index 0 is the pipeline input, index stages the output
  logic [`EX_DATA_WIDTH-1:0] prod_chain   [0:stages];
  logic [`EX_DATA_WIDTH-1:0] mplier_chain [0:stages];
  logic [`EX_DATA_WIDTH-1:0] mcand_chain  [0:stages];
  mult_tag_t                 tag_chain    [0:stages];
  logic [stages:0]           done_chain;

  assign prod_chain[0]   = '0;
  assign mplier_chain[0] = mplier;
  assign mcand_chain[0]  = mcand;
  assign tag_chain[0]    = tag_in;
  assign done_chain[0]   = start;

  for (genvar i = 0; i < stages; i++) begin : g_stage
    ex_mult_stage u_stage (
      .clock       (clock),
      .reset       (reset),
      .start       (done_chain[i]),
      .hold        (hold),
      .product_in  (prod_chain[i]),
      .mplier_in   (mplier_chain[i]),
      .mcand_in    (mcand_chain[i]),
      .tag_in      (tag_chain[i]),
      .done        (done_chain[i+1]),
      .product_out (prod_chain[i+1]),
      .mplier_out  (mplier_chain[i+1]),
      .mcand_out   (mcand_chain[i+1]),
      .tag_out     (tag_chain[i+1])
    );
  end

  assign product   = prod_chain[stages];
  assign tag_out   = tag_chain[stages];
  assign valid_out = done_chain[stages];

  // Arbiter only holds a product that is waiting at the output
  hold_needs_output: assert property (@(posedge clock) disable iff (reset)
    hold |-> valid_out)
    else $error("ex_mult: hold raised with no valid product");

endmodule

`default_nettype wire

// File: hw/ex_mult_stage.sv
//==================================================
// One multiplier pipeline slice
// Partial product of one multiplier slice, with hold
//==================================================
`default_nettype none

`include "ex_settings.svh"

module ex_mult_stage
  import ex_pkg::*;
(
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       start,
  input  logic                       hold,
  input  logic [`EX_DATA_WIDTH-1:0]  product_in,
  input  logic [`EX_DATA_WIDTH-1:0]  mplier_in,
  input  logic [`EX_DATA_WIDTH-1:0]  mcand_in,
  input  mult_tag_t                  tag_in,
  output logic                       done,
  output logic [`EX_DATA_WIDTH-1:0]  product_out,
  output logic [`EX_DATA_WIDTH-1:0]  mplier_out,
  output logic [`EX_DATA_WIDTH-1:0]  mcand_out,
  output mult_tag_t                  tag_out
);

  localparam int slice_width = `EX_MULT_SLICE_WIDTH;

  logic [`EX_DATA_WIDTH-1:0] prod_in_reg;
  logic [`EX_DATA_WIDTH-1:0] partial_prod_reg;

  // Adder sits after the registers, feeding the next slice
  assign product_out = prod_in_reg + partial_prod_reg;

  always_ff @(posedge clock) begin
    if (!hold) begin
      prod_in_reg      <= product_in;
      partial_prod_reg <= mplier_in[slice_width-1:0] * mcand_in;
      mplier_out       <= mplier_in >> slice_width;
      mcand_out        <= mcand_in << slice_width;
      tag_out          <= tag_in;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      done <= 1'b0;
    end else if (!hold) begin
      done <= start;
    end
  end

endmodule

`default_nettype wire

// File: hw/ex_pkg.sv
//==================================================
// Execute stage types
// ALU opcodes, branch result codes and the issue,
// memory return, retire and multiplier tag structs
//==================================================
`default_nettype none

`include "ex_settings.svh"

package ex_pkg;

  typedef enum logic [3:0] {
    alu_addq   = 4'h0,
    alu_subq   = 4'h1,
    alu_and    = 4'h2,
    alu_bic    = 4'h3,
    alu_bis    = 4'h4,
    alu_ornot  = 4'h5,
    alu_xor    = 4'h6,
    alu_eqv    = 4'h7,
    alu_srl    = 4'h8,
    alu_sll    = 4'h9,
    alu_sra    = 4'ha,
    alu_cmpult = 4'hb,
    alu_cmpeq  = 4'hc,
    alu_cmpule = 4'hd,
    alu_cmplt  = 4'he,
    alu_cmple  = 4'hf
  } alu_func_e;

  typedef enum logic [1:0] {
    branch_none      = 2'b00,
    branch_taken     = 2'b01,
    branch_not_taken = 2'b10,
    branch_halt      = 2'b11
  } branch_result_e;

  typedef struct packed {
    logic                         valid;
    logic                         is_mult;
    logic                         is_branch;
    alu_func_e                    alu_func;
    // Bit 2 negates, bits 1..0 pick lbc, eq, lt, le
    logic [2:0]                   br_func;
    logic [`EX_DATA_WIDTH-1:0]    opa;
    logic [`EX_DATA_WIDTH-1:0]    opb;
    logic [`EX_DATA_WIDTH-1:0]    npc;
    logic [`EX_REG_BITS-1:0]      dest_reg;
    logic [31:0]                  ir;
    logic                         predicted_taken;
    logic [`EX_HISTORY_BITS-1:0]  pht_idx;
  } ex_issue_t;

  typedef struct packed {
    logic                       valid;
    logic [`EX_REG_BITS-1:0]    tag;
    logic [`EX_DATA_WIDTH-1:0]  value;
  } ex_mem_t;

  typedef struct packed {
    logic                         valid;
    logic [`EX_DATA_WIDTH-1:0]    npc;
    logic [`EX_REG_BITS-1:0]      dest_reg;
    logic [`EX_DATA_WIDTH-1:0]    result;
    logic                         mispredict;
    branch_result_e               branch_result;
    logic [`EX_HISTORY_BITS-1:0]  pht_idx;
  } ex_retire_t;

  // Rides alongside each product through the multiplier
  typedef struct packed {
    logic [`EX_DATA_WIDTH-1:0]  npc;
    logic [`EX_REG_BITS-1:0]    dest_reg;
  } mult_tag_t;

endpackage

`default_nettype wire

// File: hw/ex_result_arbiter.sv
//==================================================
// Retire bus arbiter
// Memory over multiplier over ALU/branch, with
// issue stall and multiplier hold
//==================================================
`default_nettype none

`include "ex_settings.svh"

module ex_result_arbiter
  import ex_pkg::*;
(
  input  logic                       alu_valid,
  input  logic [`EX_DATA_WIDTH-1:0]  alu_result,
  input  ex_issue_t                  alu_issue,
  input  logic                       mispredict,
  input  branch_result_e             branch_result,
  input  logic                       mult_valid,
  input  logic [`EX_DATA_WIDTH-1:0]  mult_product,
  input  mult_tag_t                  mult_tag,
  input  ex_mem_t                    mem_in,
  output ex_retire_t                 retire,
  output logic                       stall,
  output logic                       mult_hold
);

  always_comb begin
    retire.pht_idx = alu_issue.pht_idx;
    stall          = 1'b0;
    mult_hold      = 1'b0;
    if (mem_in.valid) begin
      // Memory returns carry no PC of their own
      retire.valid         = 1'b1;
      retire.npc           = '0;
      retire.dest_reg      = mem_in.tag;
      retire.result        = mem_in.value;
      retire.mispredict    = 1'b0;
      retire.branch_result = branch_none;
      stall                = 1'b1;
      mult_hold            = mult_valid;
    end else if (mult_valid) begin
      retire.valid         = 1'b1;
      retire.npc           = mult_tag.npc;
      retire.dest_reg      = mult_tag.dest_reg;
      retire.result        = mult_product;
      retire.mispredict    = 1'b0;
      retire.branch_result = branch_none;
      stall                = 1'b1;
    end else begin
      retire.valid         = alu_valid;
      retire.npc           = alu_issue.npc;
      retire.dest_reg      = alu_issue.dest_reg;
      retire.result        = alu_result;
      retire.mispredict    = mispredict;
      retire.branch_result = branch_result;
    end
  end

  always_comb begin
    assert (!retire.mispredict ||
            (retire.branch_result inside {branch_taken, branch_not_taken}))
      else $error("ex_result_arbiter: mispredict on a non-branch result");
  end

endmodule

`default_nettype wire

// File: hw/ex_settings.svh
//==================================================
// Execute stage widths and constants
// Multiplier depth, slice width and halt encoding
//==================================================
`ifndef EX_SETTINGS_SVH
`define EX_SETTINGS_SVH

// Operand and result width
`define EX_DATA_WIDTH 64

// Destination register number width
`define EX_REG_BITS 5

// Pattern-history index width
`define EX_HISTORY_BITS 8

// Number of multiplier stages
// The design also works with 2 or 8
`define EX_MULT_STAGES 4
`define EX_MULT_SLICE_WIDTH (`EX_DATA_WIDTH / `EX_MULT_STAGES)

// Instruction word that stops the machine
`define EX_HALT_INSTRUCTION 32'h0000_0555

// ALU result for an undecodable function
`define EX_ALU_MARKER 64'hdead_beef_baad_beef

`endif

// File: hw/ex_stage.sv
//==================================================
// Execute stage top level
// ALU, branch unit, multiplier and retire arbiter
//==================================================
`default_nettype none

module ex_stage
  import ex_pkg::*;
(
  input  logic        clock,
  input  logic        reset,
  input  ex_issue_t   issue,
  input  ex_mem_t     mem_in,
  output ex_retire_t  retire,
  output logic        stall
);

  logic [$bits(issue.opa)-1:0] alu_result;
  logic [$bits(issue.opa)-1:0] mult_product;
  logic                        br_mispredict;
  branch_result_e              br_result;
  logic                        alu_valid;
  logic                        mult_start;
  logic                        mult_valid;
  logic                        mult_hold;
  mult_tag_t                   mult_tag_in;
  mult_tag_t                   mult_tag_out;

  // Multiplies enter only on an accepted issue
  assign alu_valid            = issue.valid && !issue.is_mult;
  assign mult_start           = issue.valid && issue.is_mult && !stall;
  assign mult_tag_in.npc      = issue.npc;
  assign mult_tag_in.dest_reg = issue.dest_reg;

  ex_alu u_alu (
    .func   (issue.alu_func),
    .opa    (issue.opa),
    .opb    (issue.opb),
    .result (alu_result)
  );

  ex_branch_unit u_branch (
    .issue         (issue),
    .mispredict    (br_mispredict),
    .branch_result (br_result)
  );

  ex_mult u_mult (
    .clock     (clock),
    .reset     (reset),
    .start     (mult_start),
    .hold      (mult_hold),
    .mplier    (issue.opb),
    .mcand     (issue.opa),
    .tag_in    (mult_tag_in),
    .product   (mult_product),
    .tag_out   (mult_tag_out),
    .valid_out (mult_valid)
  );

  ex_result_arbiter u_arbiter (
    .alu_valid     (alu_valid),
    .alu_result    (alu_result),
    .alu_issue     (issue),
    .mispredict    (br_mispredict),
    .branch_result (br_result),
    .mult_valid    (mult_valid),
    .mult_product  (mult_product),
    .mult_tag      (mult_tag_out),
    .mem_in        (mem_in),
    .retire        (retire),
    .stall         (stall),
    .mult_hold     (mult_hold)
  );

endmodule

`default_nettype wire

// File: project.f
+incdir+hw
hw/ex_pkg.sv
hw/ex_alu.sv
hw/ex_branch_unit.sv
hw/ex_mult_stage.sv
hw/ex_mult.sv
hw/ex_result_arbiter.sv
hw/ex_stage.sv
verification/ex_stage_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the execute stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module ex_stage_tb -f project.f -Mdir obj_dir

output=$(./obj_dir/Vex_stage_tb)
echo "$output"
echo "$output" | grep -q "^Test passed$"

// File: verification/ex_stage_tb.sv
//==================================================
// Execute stage testbench
// Directed tasks with reference models for the ALU,
// branch unit, multiplier and retire arbitration
//==================================================
`default_nettype none

`include "ex_settings.svh"

module ex_stage_tb
  import ex_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int timeout_cycles = 40;
  localparam int mult_latency   = `EX_MULT_STAGES;

  typedef logic [`EX_DATA_WIDTH-1:0] word_t;

  // One predicted or observed retirement
  typedef struct {
    ex_retire_t value;
    int         cycle;
    bit         alu_path;
    bit         mem_path;
  } retire_rec_t;

  logic        clock;
  logic        reset;
  ex_issue_t   issue;
  ex_mem_t     mem_in;
  ex_retire_t  retire;
  logic        stall;

  integer      seed;
  int          errors;
  int          cycle;
  retire_rec_t seen_q[$];
  retire_rec_t want_q[$];

  ex_stage dut_i (
    .clock  (clock),
    .reset  (reset),
    .issue  (issue),
    .mem_in (mem_in),
    .retire (retire),
    .stall  (stall)
  );

  initial clock = 1'b0;
  always #50 clock = ~clock;

  always @(posedge clock) begin
    cycle <= cycle + 1;
  end

  // Log every retirement in the middle of its cycle
  always @(negedge clock) begin : retire_monitor
    retire_rec_t rec;
    if (!reset && retire.valid) begin
      rec.value    = retire;
      rec.cycle    = cycle;
      rec.alu_path = 1'b0;
      rec.mem_path = 1'b0;
      seen_q.push_back(rec);
    end
  end

  function automatic word_t rand64();
    return {$random(seed), $random(seed)};
  endfunction

  function automatic word_t alu_model(alu_func_e func, word_t a, word_t b);
    logic signed [`EX_DATA_WIDTH-1:0] sa;
    logic signed [`EX_DATA_WIDTH-1:0] sb;
    sa = a;
    sb = b;
    case (func)
      alu_addq:   return a + b;
      alu_subq:   return a - b;
      alu_and:    return a & b;
      alu_bic:    return a & ~b;
      alu_bis:    return a | b;
      alu_ornot:  return a | ~b;
      alu_xor:    return a ^ b;
      alu_eqv:    return ~(a ^ b);
      alu_srl:    return a >> b[5:0];
      alu_sll:    return a << b[5:0];
      alu_sra:    return sa >>> b[5:0];
      alu_cmpult: return word_t'(a < b);
      alu_cmpeq:  return word_t'(a == b);
      alu_cmpule: return word_t'(a <= b);
      alu_cmplt:  return word_t'(sa < sb);
      default:    return word_t'(sa <= sb);
    endcase
  endfunction

  // Bit 2 of func inverts the condition on opa
  function automatic logic branch_outcome(logic [2:0] func, word_t a);
    logic cond;
    case (func[1:0])
      2'd0:    cond = !a[0];
      2'd1:    cond = (a == 0);
      2'd2:    cond = ($signed(a) < 0);
      default: cond = ($signed(a) <= 0);
    endcase
    return cond ^ func[2];
  endfunction

  function automatic ex_retire_t path_model(ex_issue_t op);
    ex_retire_t r;
    logic       taken;
    r               = '0;
    r.valid         = 1'b1;
    r.npc           = op.npc;
    r.dest_reg      = op.dest_reg;
    r.result        = alu_model(op.alu_func, op.opa, op.opb);
    r.pht_idx       = op.pht_idx;
    r.branch_result = branch_none;
    if (op.is_branch) begin
      taken           = branch_outcome(op.br_func, op.opa);
      r.branch_result = taken ? branch_taken : branch_not_taken;
      r.mispredict    = (taken != op.predicted_taken);
    end else if (op.ir == `EX_HALT_INSTRUCTION) begin
      r.branch_result = branch_halt;
    end
    return r;
  endfunction

  function automatic ex_retire_t mult_model(ex_issue_t op);
    ex_retire_t r;
    r               = '0;
    r.valid         = 1'b1;
    r.npc           = op.npc;
    r.dest_reg      = op.dest_reg;
    r.result        = op.opa * op.opb;
    r.branch_result = branch_none;
    return r;
  endfunction

  function automatic ex_retire_t mem_model(ex_mem_t m);
    ex_retire_t r;
    r               = '0;
    r.valid         = 1'b1;
    r.dest_reg      = m.tag;
    r.result        = m.value;
    r.branch_result = branch_none;
    return r;
  endfunction

  function automatic ex_issue_t random_issue();
    ex_issue_t op;
    word_t     bits;
    bits        = rand64();
    op          = '0;
    op.valid    = 1'b1;
    op.npc      = rand64();
    op.dest_reg = bits[`EX_REG_BITS-1:0];
    op.pht_idx  = bits[16 +: `EX_HISTORY_BITS];
    op.opa      = rand64();
    op.opb      = rand64();
    return op;
  endfunction

  task automatic check_value(input string signal, input word_t got, input word_t want);
    assert (got === want)
      else begin
        $display("FAILED at %0t: %s is %h, expected %h", $time, signal, got, want);
        errors++;
      end
  endtask

  task automatic expect_retire(input ex_retire_t value, input int cyc,
                               input bit alu_path, input bit mem_path);
    retire_rec_t rec;
    rec.value    = value;
    rec.cycle    = cyc;
    rec.alu_path = alu_path;
    rec.mem_path = mem_path;
    want_q.push_back(rec);
  endtask

  task automatic drive_idle();
    issue  <= '0;
    mem_in <= '0;
  endtask

  // Hold the issue until stall is low, return on the accepting edge
  task automatic issue_op(input ex_issue_t op, output int accept_cycle, output int waited);
    issue <= op;
    waited = 0;
    @(negedge clock);
    while (stall && waited < timeout_cycles) begin
      waited++;
      @(negedge clock);
    end
    if (stall) begin
      $display("Issue at %0t was never accepted, stall stayed high", $time);
      errors++;
    end
    accept_cycle = cycle;
    @(posedge clock);
  endtask

  task automatic compare_retires(input string name);
    retire_rec_t want;
    retire_rec_t seen;
    int          waited;
    waited = 0;
    while (seen_q.size() < want_q.size() && waited < timeout_cycles) begin
      @(posedge clock);
      waited++;
    end
    // Extra cycles expose duplicated results
    repeat (2) @(posedge clock);
    assert (seen_q.size() == want_q.size())
      else begin
        $display("%s test saw %0d retirements where %0d were expected",
                 name, seen_q.size(), want_q.size());
        errors++;
      end
    while (want_q.size() > 0 && seen_q.size() > 0) begin
      want = want_q.pop_front();
      seen = seen_q.pop_front();
      check_value("retire.result", seen.value.result, want.value.result);
      check_value("retire.dest_reg", seen.value.dest_reg, want.value.dest_reg);
      check_value("retire.branch_result", seen.value.branch_result,
                  want.value.branch_result);
      check_value("retire.mispredict", seen.value.mispredict, want.value.mispredict);
      if (!want.mem_path) begin
        check_value("retire.npc", seen.value.npc, want.value.npc);
      end
      if (want.alu_path) begin
        check_value("retire.pht_idx", seen.value.pht_idx, want.value.pht_idx);
      end
      if (want.cycle >= 0) begin
        check_value("retire cycle", seen.cycle, want.cycle);
      end
    end
    want_q.delete();
    seen_q.delete();
  endtask

  task automatic idle_after_reset();
    @(negedge clock);
    check_value("retire.valid", retire.valid, 1'b0);
    check_value("stall", stall, 1'b0);
    check_value("retire.mispredict", retire.mispredict, 1'b0);
    @(posedge clock);
  endtask

  task automatic alu_operations();
    word_t     edges [6];
    ex_issue_t op;
    int        accept;
    int        waited;
    edges = '{64'd0, 64'd1, 64'd63, 64'h8000_0000_0000_0000,
              64'hffff_ffff_ffff_ffff, 64'h7fff_ffff_ffff_fff0};
    for (int f = 0; f < 16; f++) begin
      for (int i = 0; i < 40; i++) begin
        op          = random_issue();
        op.alu_func = alu_func_e'(f);
        // Every pair of edge values, then random operands
        if (i < 36) begin
          op.opa = edges[i / 6];
          op.opb = edges[i % 6];
        end
        issue_op(op, accept, waited);
        expect_retire(path_model(op), accept, 1'b1, 1'b0);
      end
    end
    drive_idle();
    compare_retires("ALU");
  endtask

  task automatic branch_conditions();
    word_t     operands [4];
    ex_issue_t op;
    int        accept;
    int        waited;
    operands = '{64'd0, 64'hffff_ffff_ffff_fff0, 64'd5, 64'h8000_0000_0000_0001};
    for (int f = 0; f < 8; f++) begin
      for (int p = 0; p < 2; p++) begin
        for (int i = 0; i < 4; i++) begin
          op                 = random_issue();
          op.is_branch       = 1'b1;
          op.br_func         = f[2:0];
          op.predicted_taken = p[0];
          op.opa             = operands[i];
          issue_op(op, accept, waited);
          expect_retire(path_model(op), accept, 1'b1, 1'b0);
        end
      end
    end
    op    = random_issue();
    op.ir = `EX_HALT_INSTRUCTION;
    issue_op(op, accept, waited);
    expect_retire(path_model(op), accept, 1'b1, 1'b0);
    drive_idle();
    compare_retires("branch");
  endtask

  task automatic back_to_back_multiplies();
    ex_issue_t op;
    int        accept;
    int        waited;
    for (int i = 0; i < 6; i++) begin
      op         = random_issue();
      op.is_mult = 1'b1;
      issue_op(op, accept, waited);
      expect_retire(mult_model(op), accept + mult_latency, 1'b0, 1'b0);
    end
    drive_idle();
    compare_retires("multiply");
  endtask

  task automatic alu_stall_collision();
    ex_issue_t mult_op;
    ex_issue_t alu_op;
    int        accept;
    int        waited;
    mult_op         = random_issue();
    mult_op.is_mult = 1'b1;
    issue_op(mult_op, accept, waited);
    expect_retire(mult_model(mult_op), accept + mult_latency, 1'b0, 1'b0);
    drive_idle();
    // ALU issue lands on the cycle the product reaches the arbiter
    repeat (mult_latency - 1) @(posedge clock);
    alu_op          = random_issue();
    alu_op.alu_func = alu_xor;
    issue_op(alu_op, accept, waited);
    check_value("stall high cycles", waited, 1);
    expect_retire(path_model(alu_op), accept, 1'b1, 1'b0);
    drive_idle();
    compare_retires("collision");
  endtask

  task automatic memory_priority();
    ex_issue_t mult_op;
    ex_mem_t   mem_a;
    ex_mem_t   mem_b;
    word_t     bits;
    int        accept;
    int        waited;
    bits            = rand64();
    mem_a           = '{valid: 1'b1, tag: bits[4:0], value: rand64()};
    mem_b           = '{valid: 1'b1, tag: bits[12:8], value: rand64()};
    mult_op         = random_issue();
    mult_op.is_mult = 1'b1;
    issue_op(mult_op, accept, waited);
    drive_idle();
    repeat (mult_latency - 1) @(posedge clock);
    // Two memory returns hold the product back for two cycles
    mem_in <= mem_a;
    expect_retire(mem_model(mem_a), accept + mult_latency, 1'b0, 1'b1);
    @(posedge clock);
    mem_in <= mem_b;
    expect_retire(mem_model(mem_b), accept + mult_latency + 1, 1'b0, 1'b1);
    @(posedge clock);
    mem_in <= '0;
    expect_retire(mult_model(mult_op), accept + mult_latency + 2, 1'b0, 1'b0);
    compare_retires("memory");
  endtask

  initial begin
    seed   = 32'h7a389a0f;
    errors = 0;
    cycle  = 0;
    reset  <= 1'b1;
    issue  <= '0;
    mem_in <= '0;
    repeat (5) @(posedge clock);
    reset <= 1'b0;
    idle_after_reset();
    alu_operations();
    branch_conditions();
    back_to_back_multiplies();
    alu_stall_collision();
    memory_priority();
    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
